// File: rtl/link_params.svh
// link timing and register map, values assume the 24-bit summary and one 8-bit header
`ifndef LINK_PARAMS_SVH
`define LINK_PARAMS_SVH

// frame lengths in nibbles, header first
`define LINK_DATA_NIBBLES 8
`define LINK_ACK_NIBBLES 2

// idle cycles after a data frame before a retransmit
`define LINK_ACK_TIMEOUT 32
`define LINK_MAX_RETRIES 3

// apb byte addresses, 4-bit decode
`define LINK_ADDR_CTRL   4'h0
`define LINK_ADDR_TX     4'h4
`define LINK_ADDR_STATUS 4'h8
`define LINK_ADDR_RX     4'hC

`endif

// File: rtl/game_pkg.sv
// game side types, the summary layout is fixed at 24 bits by the data frame payload
package game_pkg;

    // piece codes shared by hold and queue slots
    typedef enum logic [3:0] {
        TILE_NONE    = 4'd0,
        TILE_I       = 4'd1,
        TILE_O       = 4'd2,
        TILE_T       = 4'd3,
        TILE_S       = 4'd4,
        TILE_Z       = 4'd5,
        TILE_J       = 4'd6,
        TILE_L       = 4'd7,
        TILE_GARBAGE = 4'd8
    } tile_t;

    // next[3] is the first piece on the lanes
    typedef struct packed {
        logic [3:0]  garbage;
        tile_t       hold;
        tile_t [3:0] next;
    } game_summary_t;

endpackage : game_pkg

// File: rtl/net_pkg.sv
// lane framing types, both header views keep the kind bit at bit 7
package net_pkg;

    import game_pkg::*;

    typedef enum logic {
        FRAME_DATA = 1'b0,
        FRAME_ACK  = 1'b1
    } frame_kind_t;

    typedef struct packed {
        frame_kind_t kind;
        logic        seq;
        logic        ready;
        logic        lost;
        logic [3:0]  spare;
    } data_hdr_t;

    typedef struct packed {
        frame_kind_t kind;
        logic        seq;
        logic [5:0]  spare;
    } ack_hdr_t;

    // kind bit picks which view is meaningful
    typedef union packed {
        data_hdr_t data;
        ack_hdr_t  ack;
    } frame_hdr_u;

    typedef struct packed {
        logic       frame_valid;
        logic [3:0] nibble;
    } lane_bus_t;

    // snapshot handed to the sender at send time
    typedef struct packed {
        game_summary_t summary;
        logic          ready;
        logic          lost;
    } tx_req_t;

endpackage : net_pkg

// File: rtl/link_apb_regs.sv
// zero wait state APB slave, 4-bit address decode, a send while busy is rejected with pslverr
`timescale 1ns/1ps
`include "link_params.svh"

module link_apb_regs
    import game_pkg::*,
           net_pkg::*;
(
    input  logic          clk,
    input  logic          rst_l,
    input  logic [3:0]    paddr,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [31:0]   pwdata,
    input  logic          busy,
    input  logic          fail,
    input  logic          tx_seq,
    input  logic [3:0]    retry_count,
    input  game_summary_t rx_summary,
    input  logic          opp_ready,
    input  logic          opp_lost,
    input  logic [3:0]    rx_count,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr,
    output logic          send_start,
    output tx_req_t       tx_req
);
    game_summary_t tx_q;
    logic          ready_q;
    logic          lost_q;
    logic          wr_access;
    logic          wr_ctrl;
    logic          send_bit;
    logic          ctrl_ok;

    assign wr_access = psel && penable && pwrite;
    assign wr_ctrl   = wr_access && (paddr == `LINK_ADDR_CTRL);
    assign send_bit  = pwdata[0];

    // whole ctrl write is dropped when it collides with a send in flight
    assign ctrl_ok    = wr_ctrl && !(send_bit && busy);
    assign send_start = ctrl_ok && send_bit;
    assign pslverr    = wr_ctrl && send_bit && busy;
    assign pready     = 1'b1;

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            tx_q    <= '0;
            ready_q <= 1'b0;
            lost_q  <= 1'b0;
        end else begin
            if (wr_access && (paddr == `LINK_ADDR_TX)) begin
                tx_q <= game_summary_t'(pwdata[23:0]);
            end
            if (ctrl_ok) begin
                ready_q <= pwdata[1];
                lost_q  <= pwdata[2];
            end
        end
    end

    // flags from the same write go out with the frame
    always_comb begin
        tx_req.summary = tx_q;
        tx_req.ready   = ctrl_ok ? pwdata[1] : ready_q;
        tx_req.lost    = ctrl_ok ? pwdata[2] : lost_q;
    end

    always_comb begin
        case (paddr)
            `LINK_ADDR_CTRL: begin
                prdata = {29'b0, lost_q, ready_q, 1'b0};
            end
            `LINK_ADDR_TX: begin
                prdata = {8'b0, tx_q};
            end
            `LINK_ADDR_STATUS: begin
                prdata = {16'b0, retry_count, rx_count, 3'b0,
                          tx_seq, opp_lost, opp_ready, fail, busy};
            end
            `LINK_ADDR_RX: begin
                prdata = {8'b0, rx_summary};
            end
            default: begin
                prdata = 32'b0;
            end
        endcase
    end

endmodule : link_apb_regs

// File: rtl/frame_sender.sv
// send_start is honored only in idle, the register stage blocks it while busy is high
`timescale 1ns/1ps
`include "link_params.svh"

module frame_sender
    import net_pkg::*;
(
    input  logic       clk,
    input  logic       rst_l,
    input  logic       send_start,
    input  tx_req_t    tx_req,
    input  logic       ack_req,
    input  logic       ack_seq,
    input  logic       ack_seen,
    input  logic       ack_seen_seq,
    output lane_bus_t  tx_lane,
    output logic       busy,
    output logic       fail,
    output logic       tx_seq,
    output logic [3:0] retry_count
);
    localparam int FRAME_W = `LINK_DATA_NIBBLES * 4;
    localparam int CNT_W   = $clog2(`LINK_DATA_NIBBLES);
    localparam int TIMER_W = $clog2(`LINK_ACK_TIMEOUT);

    typedef enum logic [1:0] {
        S_IDLE,
        S_DATA,
        S_WAIT,
        S_ACK
    } state_t;

    state_t             state;
    logic [FRAME_W-1:0] shreg;
    logic [CNT_W-1:0]   nib_cnt;
    logic [TIMER_W-1:0] timer;
    tx_req_t            req_q;
    logic               send_act;
    logic               got_ack;
    logic               ack_pend;
    logic               ack_pend_seq;
    logic               ack_match;
    logic               frame_last;

    function automatic logic [FRAME_W-1:0] data_frame(tx_req_t r, logic seq);
        data_hdr_t h;
        h.kind  = FRAME_DATA;
        h.seq   = seq;
        h.ready = r.ready;
        h.lost  = r.lost;
        h.spare = '0;
        return {h, r.summary};
    endfunction

    function automatic logic [FRAME_W-1:0] ack_frame(logic seq);
        ack_hdr_t h;
        h.kind  = FRAME_ACK;
        h.seq   = seq;
        h.spare = '0;
        return {h, {(FRAME_W - 8){1'b0}}};
    endfunction

    assign ack_match  = ack_seen && (ack_seen_seq == tx_seq);
    assign frame_last = ((state == S_DATA) && (nib_cnt == CNT_W'(`LINK_DATA_NIBBLES - 1))) ||
                        ((state == S_ACK) && (nib_cnt == CNT_W'(`LINK_ACK_NIBBLES - 1)));

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state       <= S_IDLE;
            nib_cnt     <= '0;
            timer       <= '0;
            send_act    <= 1'b0;
            got_ack     <= 1'b0;
            ack_pend    <= 1'b0;
            fail        <= 1'b0;
            tx_seq      <= 1'b0;
            retry_count <= '0;
        end else begin
            if (ack_req) begin
                ack_pend     <= 1'b1;
                ack_pend_seq <= ack_seq;
            end
            // ack may land while a frame is still going out
            if (send_act && ack_match) begin
                got_ack <= 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (send_start) begin
                        req_q       <= tx_req;
                        shreg       <= data_frame(tx_req, tx_seq);
                        nib_cnt     <= '0;
                        send_act    <= 1'b1;
                        got_ack     <= 1'b0;
                        fail        <= 1'b0;
                        retry_count <= '0;
                        state       <= S_DATA;
                    end else if (ack_pend) begin
                        shreg    <= ack_frame(ack_pend_seq);
                        nib_cnt  <= '0;
                        ack_pend <= ack_req;
                        state    <= S_ACK;
                    end
                end
                S_DATA, S_ACK: begin
                    shreg   <= shreg << 4;
                    nib_cnt <= nib_cnt + 1'b1;
                    if (frame_last) begin
                        timer <= '0;
                        state <= send_act ? S_WAIT : S_IDLE;
                    end
                end
                S_WAIT: begin
                    if (ack_match || got_ack) begin
                        send_act <= 1'b0;
                        got_ack  <= 1'b0;
                        tx_seq   <= ~tx_seq;
                        state    <= S_IDLE;
                    end else if (ack_pend) begin
                        // opponent ack goes ahead of a retransmit
                        shreg    <= ack_frame(ack_pend_seq);
                        nib_cnt  <= '0;
                        ack_pend <= ack_req;
                        state    <= S_ACK;
                    end else if (timer == TIMER_W'(`LINK_ACK_TIMEOUT - 1)) begin
                        if (retry_count == 4'(`LINK_MAX_RETRIES)) begin
                            send_act <= 1'b0;
                            fail     <= 1'b1;
                            state    <= S_IDLE;
                        end else begin
                            retry_count <= retry_count + 1'b1;
                            shreg       <= data_frame(req_q, tx_seq);
                            nib_cnt     <= '0;
                            state       <= S_DATA;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // an ack frame in flight also blocks a new send
    assign busy = send_act || (state != S_IDLE);

    always_comb begin
        tx_lane.frame_valid = (state == S_DATA) || (state == S_ACK);
        tx_lane.nibble      = tx_lane.frame_valid ? shreg[FRAME_W-1 -: 4] : 4'h0;
    end

endmodule : frame_sender

// File: rtl/frame_receiver.sv
// frames need at least one idle cycle between them, results land two cycles after the last nibble
`timescale 1ns/1ps
`include "link_params.svh"

module frame_receiver
    import game_pkg::*,
           net_pkg::*;
(
    input  logic          clk,
    input  logic          rst_l,
    input  lane_bus_t     rx_lane,
    output logic          ack_req,
    output logic          ack_seq,
    output logic          ack_seen,
    output logic          ack_seen_seq,
    output game_summary_t rx_summary,
    output logic          opp_ready,
    output logic          opp_lost,
    output logic [3:0]    rx_count
);
    localparam int FRAME_W = `LINK_DATA_NIBBLES * 4;
    localparam int SUM_W   = $bits(game_summary_t);

    logic [FRAME_W-1:0] shreg;
    frame_hdr_u         hdr_q;
    logic [3:0]         nib_cnt;
    logic               exp_seq;
    logic               frame_end;
    logic               len_ok;
    logic               data_ok;
    logic               ack_ok;
    logic               accept;

    assign frame_end = !rx_lane.frame_valid && (nib_cnt != 4'd0);

    // kind decides the expected length
    always_comb begin
        if (hdr_q.data.kind == FRAME_DATA) begin
            len_ok = (nib_cnt == 4'(`LINK_DATA_NIBBLES));
        end else begin
            len_ok = (nib_cnt == 4'(`LINK_ACK_NIBBLES));
        end
    end

    assign data_ok = frame_end && len_ok && (hdr_q.data.kind == FRAME_DATA);
    assign ack_ok  = frame_end && len_ok && (hdr_q.ack.kind == FRAME_ACK);
    assign accept  = data_ok && (hdr_q.data.seq == exp_seq);

    always_ff @(posedge clk) begin
        if (rx_lane.frame_valid) begin
            shreg <= {shreg[FRAME_W-5:0], rx_lane.nibble};
        end
        // header is complete with the second nibble
        if (rx_lane.frame_valid && (nib_cnt == 4'd1)) begin
            hdr_q <= frame_hdr_u'({shreg[3:0], rx_lane.nibble});
        end
        if (accept) begin
            rx_summary <= game_summary_t'(shreg[SUM_W-1:0]);
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            nib_cnt      <= 4'd0;
            exp_seq      <= 1'b0;
            ack_req      <= 1'b0;
            ack_seq      <= 1'b0;
            ack_seen     <= 1'b0;
            ack_seen_seq <= 1'b0;
            opp_ready    <= 1'b0;
            opp_lost     <= 1'b0;
            rx_count     <= 4'd0;
        end else begin
            // saturate so long runs still fail the length check
            if (rx_lane.frame_valid) begin
                nib_cnt <= (nib_cnt == 4'hF) ? 4'hF : nib_cnt + 4'd1;
            end else begin
                nib_cnt <= 4'd0;
            end

            ack_req  <= data_ok;
            ack_seen <= ack_ok;
            if (data_ok) begin
                ack_seq <= hdr_q.data.seq;
            end
            if (ack_ok) begin
                ack_seen_seq <= hdr_q.ack.seq;
            end

            // duplicates are acked but not stored
            if (accept) begin
                opp_ready <= hdr_q.data.ready;
                opp_lost  <= hdr_q.data.lost;
                rx_count  <= rx_count + 4'd1;
                exp_seq   <= ~exp_seq;
            end
        end
    end

endmodule : frame_receiver

// File: rtl/link_top.sv
// one board's link, tx_lane and rx_lane go to the opponent or are looped back for self test
`timescale 1ns/1ps

module link_top
    import game_pkg::*,
           net_pkg::*;
(
    input  logic        clk,
    input  logic        rst_l,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  lane_bus_t   rx_lane,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output lane_bus_t   tx_lane
);
    logic          send_start;
    tx_req_t       tx_req;
    logic          busy;
    logic          fail;
    logic          tx_seq;
    logic [3:0]    retry_count;
    logic          ack_req;
    logic          ack_seq;
    logic          ack_seen;
    logic          ack_seen_seq;
    game_summary_t rx_summary;
    logic          opp_ready;
    logic          opp_lost;
    logic [3:0]    rx_count;

    link_apb_regs u_regs (
        .clk         (clk),
        .rst_l       (rst_l),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .busy        (busy),
        .fail        (fail),
        .tx_seq      (tx_seq),
        .retry_count (retry_count),
        .rx_summary  (rx_summary),
        .opp_ready   (opp_ready),
        .opp_lost    (opp_lost),
        .rx_count    (rx_count),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .send_start  (send_start),
        .tx_req      (tx_req)
    );

    frame_sender u_sender (
        .clk          (clk),
        .rst_l        (rst_l),
        .send_start   (send_start),
        .tx_req       (tx_req),
        .ack_req      (ack_req),
        .ack_seq      (ack_seq),
        .ack_seen     (ack_seen),
        .ack_seen_seq (ack_seen_seq),
        .tx_lane      (tx_lane),
        .busy         (busy),
        .fail         (fail),
        .tx_seq       (tx_seq),
        .retry_count  (retry_count)
    );

    frame_receiver u_receiver (
        .clk          (clk),
        .rst_l        (rst_l),
        .rx_lane      (rx_lane),
        .ack_req      (ack_req),
        .ack_seq      (ack_seq),
        .ack_seen     (ack_seen),
        .ack_seen_seq (ack_seen_seq),
        .rx_summary   (rx_summary),
        .opp_ready    (opp_ready),
        .opp_lost     (opp_lost),
        .rx_count     (rx_count)
    );

endmodule : link_top

// File: verification/link_assert.sv
// framing checks watch tx_lane only, clocked by the shared link clock
`timescale 1ns/1ps
`include "link_params.svh"

module link_assert
    import net_pkg::*;
(
    input logic      clk,
    input logic      rst_l,
    input logic      psel,
    input logic      penable,
    input logic      pslverr,
    input lane_bus_t tx_lane
);
    logic [3:0] run_len;
    int         fail_count = 0;

    // high cycles of the current frame
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            run_len <= 4'd0;
        end else if (tx_lane.frame_valid) begin
            run_len <= (run_len == 4'hF) ? 4'hF : run_len + 4'd1;
        end else begin
            run_len <= 4'd0;
        end
    end

    frame_len_check: assert property (@(posedge clk) disable iff (!rst_l)
        $fell(tx_lane.frame_valid) |->
            (run_len == 4'(`LINK_DATA_NIBBLES)) || (run_len == 4'(`LINK_ACK_NIBBLES)))
        else begin
            $error("frame of %0d cycles on tx_lane", run_len);
            fail_count++;
        end

    slverr_phase_check: assert property (@(posedge clk) pslverr |-> psel && penable)
        else begin
            $error("pslverr outside an access phase");
            fail_count++;
        end

    reset_idle_check: assert property (@(posedge clk) !rst_l |-> !tx_lane.frame_valid)
        else begin
            $error("frame_valid high during reset");
            fail_count++;
        end

endmodule : link_assert

bind link_top link_assert u_assert (
    .clk     (clk),
    .rst_l   (rst_l),
    .psel    (psel),
    .penable (penable),
    .pslverr (pslverr),
    .tx_lane (tx_lane)
);

// File: verification/link_tb.sv
// loopback self test of one board where cut forces rx_lane idle so no frame or ack comes back
`timescale 1ns/1ps
`include "link_params.svh"

module link_tb
    import game_pkg::*,
           net_pkg::*;
();
    localparam int POLL_LIMIT = 400;
    localparam int SERIES_LEN = 6;

    logic        clk;
    logic        rst_l;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    lane_bus_t   tx_lane;
    lane_bus_t   rx_lane;
    logic        cut;

    logic [31:0] lcg_state;
    int          error_count;
    int          test_count;
    int          failed_tests;
    int          sends_done;
    bit          hung;

    link_top u_dut (
        .clk     (clk),
        .rst_l   (rst_l),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .rx_lane (rx_lane),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tx_lane (tx_lane)
    );

    // board talks to itself unless the link is cut
    assign rx_lane = cut ? lane_bus_t'(5'b0) : tx_lane;

    always #2 clk = ~clk;

    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        error_count++;
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // legal tile codes only, taken from the upper lcg bits
    function automatic game_summary_t random_summary();
        game_summary_t s;
        logic [31:0]   r;
        r         = lcg_next();
        s.garbage = r[31:28];
        s.hold    = tile_t'(4'((r >> 16) % 9));
        for (int i = 0; i < 4; i++) begin
            r         = lcg_next();
            s.next[i] = tile_t'(4'((r >> 16) % 9));
        end
        return s;
    endfunction

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        err = pslverr;
        if (pready !== 1'b1) begin
            report_error("pready low in write access phase");
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(negedge clk);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        if (pready !== 1'b1 || pslverr !== 1'b0) begin
            report_error("bad pready or pslverr on read");
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle(output logic [31:0] status);
        int polls;
        polls = 0;
        apb_read(`LINK_ADDR_STATUS, status);
        while (status[0] !== 1'b0 && polls < POLL_LIMIT) begin
            apb_read(`LINK_ADDR_STATUS, status);
            polls++;
        end
        if (status[0] !== 1'b0) begin
            $display("timeout: busy did not fall after %0d status reads", POLL_LIMIT);
            hung = 1'b1;
        end
    endtask

    task automatic start_send(input game_summary_t sum, input logic ready, input logic lost);
        logic err;
        apb_write(`LINK_ADDR_TX, {8'b0, sum}, err);
        apb_write(`LINK_ADDR_CTRL, {29'b0, lost, ready, 1'b1}, err);
        if (err !== 1'b0) begin
            report_error("pslverr on a send while idle");
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        test_count++;
        if (error_count != errors_before || hung) begin
            failed_tests++;
            $display("test %0d %s: failed", test_count, name);
        end else begin
            $display("test %0d %s: ok", test_count, name);
        end
    endtask

    task automatic test_reset_state();
        int          errs;
        logic [31:0] st;
        errs = error_count;
        apb_read(`LINK_ADDR_STATUS, st);
        if (st !== 32'h0) begin
            report_error($sformatf("STATUS after reset is %h, expected 0", st));
        end
        if (tx_lane.frame_valid !== 1'b0) begin
            report_error("frame_valid high after reset");
        end
        finish_test("reset state", errs);
    endtask

    task automatic test_loopback_send();
        int            errs;
        logic [31:0]   st0;
        logic [31:0]   st;
        logic [31:0]   rx;
        game_summary_t sum;
        errs = error_count;
        sum  = random_summary();
        apb_read(`LINK_ADDR_STATUS, st0);
        start_send(sum, 1'b1, 1'b0);
        #1;
        // data header leads with kind, seq, ready, lost
        if (tx_lane.frame_valid !== 1'b1 ||
            tx_lane.nibble !== {FRAME_DATA, st0[4], 1'b1, 1'b0}) begin
            report_error("first header nibble not on the lanes after the send write");
        end
        wait_idle(st);
        if (!hung) begin
            sends_done++;
            apb_read(`LINK_ADDR_RX, rx);
            if (rx[23:0] !== sum) begin
                report_error($sformatf("RX %h, expected %h", rx[23:0], sum));
            end
            if (st[2] !== 1'b1 || st[1] !== 1'b0 || st[4] !== ~st0[4]) begin
                report_error($sformatf("STATUS %h after loopback send", st));
            end
            if (st[11:8] !== 4'(sends_done)) begin
                report_error($sformatf("count %0d, expected %0d", st[11:8], 4'(sends_done)));
            end
        end
        finish_test("loopback send", errs);
    endtask

    task automatic test_send_series();
        int            errs;
        logic [31:0]   st;
        logic [31:0]   rx;
        logic [31:0]   r;
        game_summary_t sum;
        errs = error_count;
        for (int i = 0; i < SERIES_LEN && !hung; i++) begin
            sum = random_summary();
            r   = lcg_next();
            start_send(sum, r[20], r[27]);
            wait_idle(st);
            if (!hung) begin
                sends_done++;
                apb_read(`LINK_ADDR_RX, rx);
                if (rx[23:0] !== sum || st[2] !== r[20] || st[3] !== r[27]) begin
                    report_error($sformatf("send %0d: RX %h flags %b, expected %h flags %b",
                                           i, rx[23:0], st[3:2], sum, {r[27], r[20]}));
                end
                if (st[11:8] !== 4'(sends_done) || st[1] !== 1'b0) begin
                    report_error($sformatf("send %0d: STATUS %h, count expected %0d",
                                           i, st, 4'(sends_done)));
                end
            end
        end
        finish_test("send series", errs);
    endtask

    task automatic test_cut_link();
        int          errs;
        logic [31:0] st0;
        logic [31:0] st;
        logic [31:0] rx0;
        logic [31:0] rx;
        errs = error_count;
        apb_read(`LINK_ADDR_STATUS, st0);
        apb_read(`LINK_ADDR_RX, rx0);
        cut = 1'b1;
        start_send(random_summary(), 1'b0, 1'b1);
        wait_idle(st);
        cut = 1'b0;
        if (!hung) begin
            apb_read(`LINK_ADDR_RX, rx);
            if (st[1] !== 1'b1 || st[15:12] !== 4'(`LINK_MAX_RETRIES)) begin
                report_error($sformatf("STATUS %h, expected fail with %0d retries",
                                       st, `LINK_MAX_RETRIES));
            end
            if (st[4] !== st0[4] || st[11:8] !== st0[11:8] || rx !== rx0) begin
                report_error("seq, count or RX changed on a cut link");
            end
        end
        finish_test("cut link", errs);
    endtask

    task automatic test_send_while_busy();
        int            errs;
        logic          err;
        logic [31:0]   st;
        logic [31:0]   rx;
        logic [31:0]   ctrl;
        game_summary_t sum_a;
        game_summary_t sum_b;
        errs  = error_count;
        sum_a = random_summary();
        sum_b = ~sum_a;
        start_send(sum_a, 1'b1, 1'b0);
        apb_write(`LINK_ADDR_TX, {8'b0, sum_b}, err);
        apb_write(`LINK_ADDR_CTRL, {29'b0, 1'b1, 1'b0, 1'b1}, err);
        if (err !== 1'b1) begin
            report_error("no pslverr on a send while busy");
        end
        // rejected write must leave ready and lost as the first send set them
        apb_read(`LINK_ADDR_CTRL, ctrl);
        if (ctrl[2:0] !== 3'b010) begin
            report_error($sformatf("CTRL %h after the rejected send, expected flags 010",
                                   ctrl));
        end
        wait_idle(st);
        if (!hung) begin
            sends_done++;
            apb_read(`LINK_ADDR_RX, rx);
            if (rx[23:0] !== sum_a) begin
                report_error($sformatf("RX %h, expected first payload %h", rx[23:0], sum_a));
            end
            if (st[3:1] !== 3'b010 || st[11:8] !== 4'(sends_done)) begin
                report_error($sformatf("STATUS %h after the rejected send", st));
            end
        end
        finish_test("send while busy", errs);
    endtask

    initial begin
        clk          = 1'b0;
        rst_l        = 1'b0;
        paddr        = 4'h0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = 32'h0;
        cut          = 1'b0;
        lcg_state    = 32'd66553;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        sends_done   = 0;
        hung         = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_l = 1'b1;

        if (!hung) test_reset_state();
        if (!hung) test_loopback_send();
        if (!hung) test_send_series();
        if (!hung) test_cut_link();
        if (!hung) test_send_while_busy();

        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 test_count, failed_tests, error_count, u_dut.u_assert.fail_count);
        if (hung || error_count != 0 || u_dut.u_assert.fail_count != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule : link_tb

// File: filelist.f
+incdir+rtl
rtl/game_pkg.sv
rtl/net_pkg.sv
rtl/link_apb_regs.sv
rtl/frame_sender.sv
rtl/frame_receiver.sv
rtl/link_top.sv
verification/link_assert.sv
verification/link_tb.sv

// File: Makefile
# Verilator build and run for the link testbench

VERILATOR  ?= verilator
TOP        ?= link_tb
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_TEXT  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP)_sim -f $(FILELIST)
	-./$(BUILD_DIR)/$(TOP)_sim $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
